// File: design/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

module data_ram (
    input  wire logic                  clk,
    input  wire mem_bus_pkg::mem_req_t mem_req_i,
    output mem_bus_pkg::mem_word_u     rdata_o
);

    localparam int index_width = $clog2(`MEM_DEPTH_WORDS);

    mem_bus_pkg::mem_word_u mem [`MEM_DEPTH_WORDS];
    logic [index_width-1:0] index;

    // Word index from address bit 2 upwards.
    // Higher address bits are ignored, so accesses wrap around the array.
    assign index = mem_req_i.address[index_width+1:2];

    // The read is combinational and is driven only while a load is in the stage.
    assign rdata_o = mem_req_i.rd ? mem[index] : '0;

    // Byte-enabled write at the clock edge.
    always_ff @(posedge clk) begin
        if (mem_req_i.wr) begin
            for (int i = 0; i < 4; i++) begin
                if (mem_req_i.byte_en[i]) begin
                    mem[index].bytes[i] <= mem_req_i.wdata.bytes[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    // One memory word, seen whole, as two halfwords or as four bytes.
    // Index 0 of each lane view is the least significant lane.
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] halves;
        logic [3:0][7:0]  bytes;
    } mem_word_u;

    // Request from the memory stage to the data memory.
    // The byte enables apply to writes only.
    typedef struct packed {
        logic [31:0] address;
        mem_word_u   wdata;
        logic [3:0]  byte_en;
        // The read strobe is high for loads.
        logic        rd;
        // The write strobe is high for stores that are not flushed.
        logic        wr;
    } mem_req_t;

endpackage

`default_nettype wire

// File: design/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Access operation codes carried in the execute bundle.
// D2R passes the execute result straight to writeback.
`define ACCESS_OP_D2R 2'b00
// M2R loads from the data memory into a register.
`define ACCESS_OP_M2R 2'b01
// R2M stores a register value into the data memory.
`define ACCESS_OP_R2M 2'b10

// Access size codes.
// Any code other than byte or half is treated as a full word.
`define ACCESS_SZ_BYTE 2'b00
`define ACCESS_SZ_HALF 2'b01
`define ACCESS_SZ_WORD 2'b10

// Number of 32-bit words in the data memory.
// The RAM index width is derived from this value.
`define MEM_DEPTH_WORDS 256

`endif

// File: design/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

module mem_stage (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire pipe_pkg::ex_mem_t      ex_mem_i,
    input  wire logic                   exception_flush_i,
    input  wire mem_bus_pkg::mem_word_u rdata_i,
    output mem_bus_pkg::mem_req_t       mem_req_o,
    output pipe_pkg::mem_wb_t           mem_wb_o
);

    logic [3:0]  byte_en;
    logic [15:0] load_half;
    logic [7:0]  load_byte;
    logic [31:0] load_data;
    logic [31:0] store_data;
    logic [31:0] wb_data;
    logic        wb_we;

    // Byte enables follow the access size and the low address bits.
    always_comb begin
        case (ex_mem_i.size)
            `ACCESS_SZ_HALF: begin
                byte_en = ex_mem_i.addr[1] ? 4'b1100 : 4'b0011;
            end
            `ACCESS_SZ_BYTE: begin
                byte_en = 4'b0001 << ex_mem_i.addr[1:0];
            end
            default: begin
                byte_en = 4'b1111;
            end
        endcase
    end

    // The same lane selection picks the load data out of the read word,
    // which is then sign or zero extended.
    always_comb begin
        load_half = rdata_i.halves[ex_mem_i.addr[1]];
        load_byte = rdata_i.bytes[ex_mem_i.addr[1:0]];
        case (ex_mem_i.size)
            `ACCESS_SZ_HALF: begin
                if (ex_mem_i.is_unsigned) begin
                    load_data = {16'b0, load_half};
                end else begin
                    load_data = {{16{load_half[15]}}, load_half};
                end
            end
            `ACCESS_SZ_BYTE: begin
                if (ex_mem_i.is_unsigned) begin
                    load_data = {24'b0, load_byte};
                end else begin
                    load_data = {{24{load_byte[7]}}, load_byte};
                end
            end
            default: begin
                load_data = rdata_i.word;
            end
        endcase
    end

    // Store data is replicated across all lanes, so the byte enables
    // alone decide which part of the word is written.
    always_comb begin
        case (ex_mem_i.size)
            `ACCESS_SZ_HALF: store_data = {2{ex_mem_i.data[15:0]}};
            `ACCESS_SZ_BYTE: store_data = {4{ex_mem_i.data[7:0]}};
            default:         store_data = ex_mem_i.data;
        endcase
    end

    // Operation decode for the memory request.
    always_comb begin
        mem_req_o.address    = ex_mem_i.addr;
        mem_req_o.byte_en    = byte_en;
        mem_req_o.rd         = ex_mem_i.op == `ACCESS_OP_M2R;
        mem_req_o.wr         = ex_mem_i.op == `ACCESS_OP_R2M && !exception_flush_i;
        mem_req_o.wdata.word = (ex_mem_i.op == `ACCESS_OP_R2M) ? store_data : 32'b0;
    end

    // Operation decode for the writeback value.
    always_comb begin
        wb_data = ex_mem_i.data;
        wb_we   = 1'b0;
        case (ex_mem_i.op)
            `ACCESS_OP_M2R: begin
                wb_data = load_data;
                wb_we   = 1'b1;
            end
            `ACCESS_OP_D2R: begin
                wb_we = 1'b1;
            end
            default: begin
                wb_we = 1'b0;
            end
        endcase
        // A flushed instruction and a write to register 0 leave the
        // register file untouched.
        if (exception_flush_i || ex_mem_i.reg_addr == 5'd0) begin
            wb_we = 1'b0;
        end
    end

    // MEM/WB pipeline register.
    always_ff @(posedge clk) begin
        mem_wb_o.reg_addr <= ex_mem_i.reg_addr;
        mem_wb_o.data     <= wb_data;
        if (reset_i) begin
            mem_wb_o.reg_we <= 1'b0;
        end else begin
            mem_wb_o.reg_we <= wb_we;
        end
    end

endmodule

`default_nettype wire

// File: design/mem_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire pipe_pkg::ex_mem_t ex_mem_i,
    input  wire logic              exception_flush_i,
    output pipe_pkg::mem_wb_t      mem_wb_o
);

    // Request from the stage to the RAM and the word read back.
    mem_bus_pkg::mem_req_t  mem_req;
    mem_bus_pkg::mem_word_u rdata;

    mem_stage mem_stage_i (
        .clk               (clk),
        .reset_i           (reset_i),
        .ex_mem_i          (ex_mem_i),
        .exception_flush_i (exception_flush_i),
        .rdata_i           (rdata),
        .mem_req_o         (mem_req),
        .mem_wb_o          (mem_wb_o)
    );

    // The RAM answers in the same cycle, so the stage never waits.
    data_ram data_ram_i (
        .clk       (clk),
        .mem_req_i (mem_req),
        .rdata_o   (rdata)
    );

endmodule

`default_nettype wire

// File: design/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // Instruction bundle handed over by the execute stage.
    // The op and size fields use the ACCESS_OP and ACCESS_SZ codes.
    typedef struct packed {
        logic [1:0]  op;
        logic [1:0]  size;
        // Selects zero extension for byte and halfword loads.
        logic        is_unsigned;
        logic [4:0]  reg_addr;
        // Effective address of a load or store.
        logic [31:0] addr;
        // Execute result for pass-through, or the value to store.
        logic [31:0] data;
    } ex_mem_t;

    // Bundle held in the MEM/WB register for the writeback stage.
    typedef struct packed {
        logic        reg_we;
        logic [4:0]  reg_addr;
        logic [31:0] data;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

log=sim.log
build_dir=obj_dir
sim_exe=mem_subsystem_tb

if ! verilator --binary --timing --assert -f vlog.f \
        --top-module mem_subsystem_tb --Mdir "$build_dir" -o "$sim_exe"; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$build_dir/$sim_exe" > "$log" 2>&1; then
    cat "$log"
    echo "Simulation exited with a failing status"
    exit 1
fi

cat "$log"

if grep -q "Errors found" "$log"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0

// File: tb/mem_subsystem_properties.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

module mem_subsystem_properties (
    input wire logic                  clk,
    input wire logic                  reset_i,
    input wire pipe_pkg::ex_mem_t     ex_mem_i,
    input wire logic                  exception_flush_i,
    input wire mem_bus_pkg::mem_req_t mem_req_i,
    input wire pipe_pkg::mem_wb_t     mem_wb_i
);

    // The RAM has a single port, so a cycle either reads or writes.
    rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset_i)
        !(mem_req_i.rd && mem_req_i.wr))
        else $error("read and write strobes high in the same cycle");

    no_write_on_flush: assert property (@(posedge clk) disable iff (reset_i)
        exception_flush_i |-> !mem_req_i.wr)
        else $error("write strobe high during an exception flush");

    store_has_lanes: assert property (@(posedge clk) disable iff (reset_i)
        (ex_mem_i.op == `ACCESS_OP_R2M) |-> (mem_req_i.byte_en != 4'b0000))
        else $error("store issued with no byte enable set");

    // Reset clears the writeback enable at the next edge.
    reset_clears_we: assert property (@(posedge clk)
        reset_i |=> !mem_wb_i.reg_we)
        else $error("writeback enable high in the cycle after reset");

endmodule

`default_nettype wire

// File: tb/mem_subsystem_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_macros.svh"

module mem_subsystem_tb;

    localparam int idx_w = $clog2(`MEM_DEPTH_WORDS);
    localparam int reset_cycles = 5;
    localparam int test_cycles = `MEM_DEPTH_WORDS + 32 * 2 + 24 * 4 + 64 + 48 + 16 * 3
                                 + reset_cycles + 400;
    localparam int max_cycles = reset_cycles + test_cycles + 7 * 4 + 100;

    logic               clk = 1'b0;
    logic               reset_i;
    pipe_pkg::ex_mem_t  ex_mem_i;
    logic               exception_flush_i;
    pipe_pkg::mem_wb_t  mem_wb_o;

    logic [15:0] lfsr = 16'd63;
    logic [31:0] shadow [`MEM_DEPTH_WORDS];
    logic        pending = 1'b0;
    logic        exp_we;
    logic [4:0]  exp_reg;
    logic [31:0] exp_data;
    string       test_name;
    int          test_checks;
    int          test_errors;
    int          total_checks = 0;
    int          total_errors = 0;
    int          total_tests = 0;
    int          cycle_count = 0;

    mem_subsystem dut_i (
        .clk               (clk),
        .reset_i           (reset_i),
        .ex_mem_i          (ex_mem_i),
        .exception_flush_i (exception_flush_i),
        .mem_wb_o          (mem_wb_o)
    );

    bind mem_stage mem_subsystem_properties props_i (
        .clk               (clk),
        .reset_i           (reset_i),
        .ex_mem_i          (ex_mem_i),
        .exception_flush_i (exception_flush_i),
        .mem_req_i         (mem_req_o),
        .mem_wb_i          (mem_wb_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Errors found");
            $finish;
        end
    end

    // Fibonacci LFSR with taps at bits 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'b0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = rand_bits(1);
        return r[0];
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = rand_bits(5);
        return r[4:0];
    endfunction

    function automatic logic [1:0] rand_size();
        logic [31:0] r;
        r = rand_bits(2);
        if (r[1:0] == 2'd0) begin
            return `ACCESS_SZ_BYTE;
        end else if (r[1:0] == 2'd1) begin
            return `ACCESS_SZ_HALF;
        end
        return `ACCESS_SZ_WORD;
    endfunction

    // Aligned to the access size and inside the RAM.
    function automatic logic [31:0] rand_addr(input logic [1:0] size);
        logic [31:0] a;
        logic [31:0] low;
        a = rand_bits(idx_w) << 2;
        low = rand_bits(2);
        if (size == `ACCESS_SZ_BYTE) begin
            a[1:0] = low[1:0];
        end else if (size == `ACCESS_SZ_HALF) begin
            a[1] = low[1];
        end
        return a;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] w);
        return {w[7:0] ^ 8'h5a, ~w[7:0], w[7:0] + 8'h81, w[7:0]};
    endfunction

    function automatic pipe_pkg::ex_mem_t make_ex(input logic [1:0] op, input logic [1:0] size,
                                                  input logic is_unsigned, input logic [4:0] rd,
                                                  input logic [31:0] addr, input logic [31:0] data);
        pipe_pkg::ex_mem_t ex;
        ex.op = op;
        ex.size = size;
        ex.is_unsigned = is_unsigned;
        ex.reg_addr = rd;
        ex.addr = addr;
        ex.data = data;
        return ex;
    endfunction

    // Bits of the word touched by an access of this size at this offset.
    function automatic logic [31:0] lane_mask(input logic [1:0] size, input logic [1:0] low);
        if (size == `ACCESS_SZ_BYTE) begin
            return 32'h0000_00ff << {low, 3'b000};
        end else if (size == `ACCESS_SZ_HALF) begin
            return 32'h0000_ffff << {low[1], 4'b0000};
        end
        return 32'hffff_ffff;
    endfunction

    function automatic logic [31:0] replicate(input logic [31:0] d, input logic [1:0] size);
        if (size == `ACCESS_SZ_BYTE) begin
            return {4{d[7:0]}};
        end else if (size == `ACCESS_SZ_HALF) begin
            return {2{d[15:0]}};
        end
        return d;
    endfunction

    function automatic logic [31:0] load_value(input logic [31:0] word, input logic [1:0] size,
                                               input logic [1:0] low, input logic is_unsigned);
        logic [31:0] shifted;
        shifted = word >> {low, 3'b000};
        if (size == `ACCESS_SZ_BYTE) begin
            return is_unsigned ? {24'b0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
        end else if (size == `ACCESS_SZ_HALF) begin
            return is_unsigned ? {16'b0, shifted[15:0]} : {{16{shifted[15]}}, shifted[15:0]};
        end
        return word;
    endfunction

    task automatic check_value(input string field, input logic [63:0] expected,
                               input logic [63:0] actual);
        test_checks++;
        if (expected !== actual) begin
            $display("error %s %s: expected %0h actual %0h", test_name, field, expected, actual);
            test_errors++;
        end
    endtask

    task automatic compare_wb();
        check_value("reg_we", 64'(exp_we), 64'(mem_wb_o.reg_we));
        if (exp_we) begin
            check_value("reg_addr", 64'(exp_reg), 64'(mem_wb_o.reg_addr));
            check_value("data", 64'(exp_data), 64'(mem_wb_o.data));
        end
    endtask

    // Checks the previous instruction, then issues the next one and
    // works out what the MEM/WB register should hold after the edge.
    task automatic step(input pipe_pkg::ex_mem_t ex, input logic flush);
        logic [idx_w-1:0] idx;
        logic [31:0]      mask;
        @(posedge clk);
        #5;
        if (pending) begin
            compare_wb();
        end
        #5;
        ex_mem_i = ex;
        exception_flush_i = flush;
        idx = ex.addr[idx_w+1:2];
        mask = lane_mask(ex.size, ex.addr[1:0]);
        exp_we = (ex.op != `ACCESS_OP_R2M) && !flush && (ex.reg_addr != 5'd0);
        exp_reg = ex.reg_addr;
        exp_data = ex.data;
        if (ex.op == `ACCESS_OP_M2R) begin
            exp_data = load_value(shadow[idx], ex.size, ex.addr[1:0], ex.is_unsigned);
        end
        if (ex.op == `ACCESS_OP_R2M && !flush) begin
            shadow[idx] = (shadow[idx] & ~mask) | (replicate(ex.data, ex.size) & mask);
        end
        pending = 1'b1;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        step(make_ex(`ACCESS_OP_D2R, `ACCESS_SZ_WORD, 1'b0, 5'd0, 32'b0, 32'b0), 1'b0);
        @(posedge clk);
        #5;
        compare_wb();
        pending = 1'b0;
        $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        total_tests++;
    endtask

    task automatic reset_pulse();
        @(posedge clk);
        #10;
        reset_i = 1'b1;
        // Would write register 7 if reset did not hold the enable low.
        ex_mem_i = make_ex(`ACCESS_OP_D2R, `ACCESS_SZ_WORD, 1'b0, 5'd7, 32'b0, 32'hdead_beef);
        exception_flush_i = 1'b0;
        repeat (reset_cycles) begin
            @(posedge clk);
            #5;
            check_value("reg_we in reset", 64'd0, 64'(mem_wb_o.reg_we));
        end
        #5;
        reset_i = 1'b0;
        ex_mem_i = make_ex(`ACCESS_OP_D2R, `ACCESS_SZ_WORD, 1'b0, 5'd0, 32'b0, 32'b0);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] r;
        logic [1:0]  sz;
        logic [1:0]  op;
        reset_i = 1'b1;
        exception_flush_i = 1'b0;
        ex_mem_i = make_ex(`ACCESS_OP_D2R, `ACCESS_SZ_WORD, 1'b0, 5'd0, 32'b0, 32'b0);
        repeat (reset_cycles) @(posedge clk);
        #10;
        reset_i = 1'b0;

        // Every word gets a known value so later loads never see X.
        begin_test("memory_init");
        for (int i = 0; i < `MEM_DEPTH_WORDS; i++) begin
            step(make_ex(`ACCESS_OP_R2M, `ACCESS_SZ_WORD, 1'b0, 5'd0, 32'(i) << 2,
                         fill_word(32'(i))), 1'b0);
        end
        end_test();

        begin_test("word_store_load");
        repeat (32) begin
            a = rand_addr(`ACCESS_SZ_WORD);
            step(make_ex(`ACCESS_OP_R2M, `ACCESS_SZ_WORD, 1'b0, rand_reg(), a, rand_bits(32)), 1'b0);
            step(make_ex(`ACCESS_OP_M2R, `ACCESS_SZ_WORD, 1'b0, rand_reg(), a, 32'b0), 1'b0);
        end
        end_test();

        begin_test("subword_merge");
        repeat (24) begin
            a = rand_addr(`ACCESS_SZ_WORD);
            step(make_ex(`ACCESS_OP_R2M, `ACCESS_SZ_WORD, 1'b0, rand_reg(), a, rand_bits(32)), 1'b0);
            step(make_ex(`ACCESS_OP_R2M, `ACCESS_SZ_HALF, 1'b0, rand_reg(),
                         a | (rand_bits(1) << 1), rand_bits(32)), 1'b0);
            step(make_ex(`ACCESS_OP_R2M, `ACCESS_SZ_BYTE, 1'b0, rand_reg(),
                         a | rand_bits(2), rand_bits(32)), 1'b0);
            step(make_ex(`ACCESS_OP_M2R, `ACCESS_SZ_WORD, 1'b0, rand_reg(), a, 32'b0), 1'b0);
        end
        end_test();

        begin_test("subword_load");
        repeat (64) begin
            sz = rand_bit() ? `ACCESS_SZ_HALF : `ACCESS_SZ_BYTE;
            a = rand_addr(sz);
            step(make_ex(`ACCESS_OP_M2R, sz, rand_bit(), rand_reg(), a, 32'b0), 1'b0);
        end
        end_test();

        begin_test("pass_through");
        for (int i = 0; i < 48; i++) begin
            if (i % 6 == 0) begin
                a = rand_addr(`ACCESS_SZ_WORD);
                step(make_ex(`ACCESS_OP_M2R, `ACCESS_SZ_WORD, 1'b0, 5'd0, a, 32'b0), 1'b0);
            end else begin
                step(make_ex(`ACCESS_OP_D2R, `ACCESS_SZ_WORD, 1'b0,
                             (i % 6 == 3) ? 5'd0 : rand_reg(), 32'b0, rand_bits(32)), 1'b0);
            end
        end
        end_test();

        begin_test("flush");
        repeat (16) begin
            sz = rand_size();
            a = rand_addr(sz);
            step(make_ex(`ACCESS_OP_R2M, sz, 1'b0, rand_reg(), a, rand_bits(32)), 1'b1);
            step(make_ex(`ACCESS_OP_M2R, sz, rand_bit(), rand_reg(), a, 32'b0), 1'b1);
            step(make_ex(`ACCESS_OP_M2R, `ACCESS_SZ_WORD, 1'b0, rand_reg(), a & ~32'd3, 32'b0),
                 1'b0);
        end
        end_test();

        begin_test("reset_then_random");
        reset_pulse();
        repeat (400) begin
            r = rand_bits(2);
            sz = rand_size();
            a = rand_addr(sz);
            if (r[1:0] == 2'd1) begin
                op = `ACCESS_OP_M2R;
            end else if (r[1:0] == 2'd2) begin
                op = `ACCESS_OP_R2M;
            end else begin
                op = `ACCESS_OP_D2R;
            end
            step(make_ex(op, sz, rand_bit(), rand_reg(), a, rand_bits(32)), rand_bits(3) == 32'd0);
        end
        end_test();

        $display("%0d tests, %0d checks, %0d errors", total_tests, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/mem_bus_pkg.sv
design/pipe_pkg.sv
design/data_ram.sv
design/mem_stage.sv
design/mem_subsystem.sv
tb/mem_subsystem_properties.sv
tb/mem_subsystem_tb.sv
